/* conv_fifo.sv */
`timescale 1ns/1ps
`include "int_float_conv_config.svh"

module conv_fifo (
        input  logic              clk,
        input  logic              rst,
        input  logic              in_stb,
        input  fp_pkg::conv_req_t in_req,
        conv_req_if.fifo_side     q,
        output logic              full,
        output logic              overflow
);
        import fp_pkg::*;

        localparam int PTR_W = $clog2(`CONV_FIFO_DEPTH);
        localparam logic [PTR_W:0] DEPTH = (PTR_W + 1)'(`CONV_FIFO_DEPTH);

        conv_req_t        mem [`CONV_FIFO_DEPTH];
        logic [PTR_W-1:0] wr_ptr;
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W:0]   count;        // Occupancy, 0 to DEPTH.
        logic             push;
        logic             pop;

        assign full      = (count == DEPTH);
        assign push      = in_stb && !full;     // Strobes while full are dropped.
        assign pop       = q.start && q.pending;
        assign q.pending = (count != '0);
        assign q.req     = mem[rd_ptr];

        // Pointers, occupancy and the sticky loss flag.
        always_ff @(posedge clk) begin
                if (!rst) begin
                        wr_ptr   <= '0;
                        rd_ptr   <= '0;
                        count    <= '0;
                        overflow <= 1'b0;
                end else begin
                        if (push) begin
                                wr_ptr <= wr_ptr + 1'b1;  // Wraps at the power of two.
                        end
                        if (pop) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                        case ({push, pop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                        if (in_stb && full) begin
                                overflow <= 1'b1;       // Held until reset.
                        end
                end
        end

        // Storage.
        always_ff @(posedge clk) begin
                if (push) begin
                        mem[wr_ptr] <= in_req;
                end
        end

endmodule

/* conv_req_if.sv */
`timescale 1ns/1ps

// Link between the request queue and the converter.
interface conv_req_if;
        import fp_pkg::*;

        conv_req_t req;         // Head of the queue.
        logic      pending;     // Queue not empty.
        logic      start;       // Converter takes the head this cycle.
        logic      busy;        // Conversion in progress.

        modport fifo_side (
                output req,
                output pending,
                input  start
        );

        modport conv_side (
                input  req,
                input  pending,
                output start,
                output busy
        );

endinterface

/* fp_pkg.sv */
`include "int_float_conv_config.svh"

package fp_pkg;

        // IEEE 754 single precision field widths.
        parameter int FP_EXP_BITS  = 8;
        parameter int FP_MANT_BITS = 23;
        parameter int FP_EXP_BIAS  = 127;

        // One queued conversion request, 33 bits.
        typedef struct packed {
                logic [`CONV_WIDTH-1:0] operand;
                logic                   is_signed;   // Two's complement operand.
        } conv_req_t;

        // Converter FSM states.
        typedef enum logic [2:0] {
                ST_IDLE      = 3'd0,
                ST_NORMALIZE = 3'd1,
                ST_ROUND     = 3'd2,
                ST_PACK      = 3'd3,
                ST_PUT       = 3'd4
        } conv_state_t;

endpackage

/* int_float_conv.f */
+incdir+.
fp_pkg.sv
conv_req_if.sv
conv_fifo.sv
int_to_float.sv
int_float_conv.sv
int_float_conv_props.sv
int_float_conv_tb.sv

/* int_float_conv.sv */
`timescale 1ns/1ps
`include "int_float_conv_config.svh"

// Queued integer to single precision converter.
module int_float_conv (
        input  logic                   clk,
        input  logic                   rst,
        input  logic                   in_stb,
        input  logic [`CONV_WIDTH-1:0] in_data,
        input  logic                   in_signed,
        output logic                   out_stb,
        output logic [`CONV_WIDTH-1:0] out_data,
        output logic                   full,
        output logic                   overflow
);
        import fp_pkg::*;

        conv_req_t in_req;

        assign in_req.operand   = in_data;
        assign in_req.is_signed = in_signed;

        conv_req_if q_if ();

        // Request queue.
        conv_fifo conv_fifo_inst (
                .clk      (clk),
                .rst      (rst),
                .in_stb   (in_stb),
                .in_req   (in_req),
                .q        (q_if.fifo_side),
                .full     (full),
                .overflow (overflow)
        );

        // One conversion at a time.
        int_to_float int_to_float_inst (
                .clk      (clk),
                .rst      (rst),
                .q        (q_if.conv_side),
                .out_stb  (out_stb),
                .out_data (out_data)
        );

endmodule

/* int_float_conv_config.svh */
`ifndef INT_FLOAT_CONV_CONFIG_SVH
`define INT_FLOAT_CONV_CONFIG_SVH

// Number of requests that can wait in the queue.
// Powers of two from 2 to 16 are supported.
`define CONV_FIFO_DEPTH 4

// Integer operand width, tied to the single precision format.
`define CONV_WIDTH 32

`endif

/* int_float_conv_props.sv */
`timescale 1ns/1ps

// Protocol checks on the converter top level.
module int_float_conv_props (
        input logic clk,
        input logic rst,
        input logic out_stb,
        input logic full,
        input logic overflow
);

        // Each result is a single cycle pulse.
        stb_single: assert property (@(posedge clk) disable iff (!rst)
                out_stb |=> !out_stb)
                else $error("out_stb stayed high for two cycles");

        // Lost requests stay recorded until reset.
        ovf_sticky: assert property (@(posedge clk) disable iff (!rst)
                overflow |=> overflow)
                else $error("overflow dropped without a reset");

        reset_quiet: assert property (@(posedge clk)
                !rst |=> (!out_stb && !full))
                else $error("out_stb or full high in the cycle after reset");

endmodule

bind int_float_conv int_float_conv_props int_float_conv_props_inst (
        .clk      (clk),
        .rst      (rst),
        .out_stb  (out_stb),
        .full     (full),
        .overflow (overflow)
);

/* int_float_conv_tb.sv */
`timescale 1ns/1ps
`include "int_float_conv_config.svh"

module int_float_conv_tb;
        import fp_pkg::*;

        localparam int N_DIRECTED  = 25;
        localparam int N_BURSTS    = 6;
        localparam int OVF_STROBES = `CONV_FIFO_DEPTH + 3;
        localparam int N_REQ       = N_DIRECTED + N_BURSTS * `CONV_FIFO_DEPTH + OVF_STROBES;
        localparam int MAX_LATENCY = 40;        // Longest conversion plus queue entry.
        localparam int LIMIT       = N_REQ * MAX_LATENCY + 200;  // Worst case plus drain.

        logic        clk;
        logic        rst;
        logic        in_stb;
        logic [31:0] in_data;
        logic        in_signed;
        logic        out_stb;
        logic [31:0] out_data;
        logic        full;
        logic        overflow;

        logic [31:0] exp_q [$];         // Expected results in request order.
        string       name_q [$];
        int          mismatch_count;
        int          other_count;
        int          cycles;

        int_float_conv int_float_conv_inst (
                .clk       (clk),
                .rst       (rst),
                .in_stb    (in_stb),
                .in_data   (in_data),
                .in_signed (in_signed),
                .out_stb   (out_stb),
                .out_data  (out_data),
                .full      (full),
                .overflow  (overflow)
        );

        always #5 clk = ~clk;

        // IEEE 754 single precision with ties rounded to even.
        function automatic logic [31:0] float_ref(input logic [31:0] value, input logic sgn);
                logic        sign;
                logic [31:0] mag;
                logic [31:0] norm;
                logic [24:0] mant;
                logic        guard;
                logic        sticky;
                int          top;
                int          e;
                sign = sgn && value[31];
                mag  = sign ? (~value + 32'd1) : value;
                if (mag == 32'd0) begin
                        return 32'd0;
                end
                top = 0;
                for (int i = 0; i < 32; i++) begin
                        if (mag[i]) begin
                                top = i;
                        end
                end
                norm   = mag << (31 - top);     // Leading one at bit 31.
                mant   = {1'b0, norm[31:8]};
                guard  = norm[7];
                sticky = |norm[6:0];
                e      = top;
                if (guard && (sticky || mant[0])) begin
                        mant = mant + 25'd1;
                end
                if (mant[24]) begin             // Carry out of the mantissa.
                        mant = mant >> 1;
                        e    = e + 1;
                end
                return {sign, 8'(e + FP_EXP_BIAS), mant[22:0]};
        endfunction

        task automatic print_error_counts();
                $display("Errors: %0d value mismatches, %0d other failures",
                         mismatch_count, other_count);
        endtask

        task automatic check_flag(input string name, input logic want, input logic got);
                assert (got === want) else begin
                        $display("Fail %s expected %b actual %b", name, want, got);
                        mismatch_count++;
                end
        endtask

        // One strobe cycle; the caller sits on a falling edge.
        task automatic strobe(input logic [31:0] value, input logic sgn,
                              input string name, input bit accept);
                in_stb    = 1'b1;
                in_data   = value;
                in_signed = sgn;
                if (accept) begin
                        exp_q.push_back(float_ref(value, sgn));
                        name_q.push_back(name);
                end
                @(negedge clk);
        endtask

        // Wait for every outstanding result, then let the FSM settle in idle.
        task automatic drain();
                while (exp_q.size() != 0) begin
                        @(negedge clk);
                end
                repeat (2) @(negedge clk);
        endtask

        task automatic check_case(input string name, input logic [31:0] value, input logic sgn);
                strobe(value, sgn, name, 1'b1);
                in_stb = 1'b0;
                drain();
        endtask

        // Operands below 2^8 keep the converter busy for the whole burst.
        task automatic overflow_burst();
                int          count;
                bit          conv_busy;
                bit          accept;
                bit          pop;
                logic [31:0] value;
                count     = 0;
                conv_busy = 1'b0;
                for (int k = 0; k < OVF_STROBES; k++) begin
                        value  = 32'($urandom_range(255, 1));
                        accept = (count < `CONV_FIFO_DEPTH);
                        pop    = !conv_busy && (count > 0);
                        count  = count + int'(accept) - int'(pop);
                        if (pop) begin
                                conv_busy = 1'b1;
                        end
                        strobe(value, 1'b0, $sformatf("overflow_%0d", k), accept);
                end
                in_stb = 1'b0;
        endtask

        always @(negedge clk) begin : compare
                logic [31:0] want;
                string       name;
                if (rst && out_stb) begin
                        if (exp_q.size() == 0) begin
                                $display("Result %h arrived with no request outstanding",
                                         out_data);
                                other_count++;
                        end else begin
                                want = exp_q.pop_front();
                                name = name_q.pop_front();
                                assert (out_data === want) else begin
                                        $display("Fail %s expected %h actual %h",
                                                 name, want, out_data);
                                        mismatch_count++;
                                end
                        end
                end
        end

        always @(posedge clk) begin
                cycles++;
                if (cycles >= LIMIT) begin
                        $display("Run stopped after %0d cycles with %0d results missing",
                                 cycles, exp_q.size());
                        foreach (name_q[i]) begin
                                $display("No result for request %s", name_q[i]);
                        end
                        other_count++;
                        print_error_counts();
                        $display("Simulation FAILED");
                        $finish;
                end
        end

        initial begin
                logic [31:0] rnd;
                logic        rsgn;
                void'($urandom(32'hca4d23b6));
                clk            = 1'b0;
                rst            = 1'b0;
                in_stb         = 1'b0;
                in_data        = 32'd0;
                in_signed      = 1'b0;
                mismatch_count = 0;
                other_count    = 0;
                cycles         = 0;
                repeat (10) @(negedge clk);
                rst = 1'b1;
                @(negedge clk);
                check_flag("reset_full", 1'b0, full);
                check_flag("reset_overflow", 1'b0, overflow);

                check_case("u_one", 32'h0000_0001, 1'b0);       // Exact values.
                check_case("u_two", 32'h0000_0002, 1'b0);
                check_case("u_pow15", 32'h0000_8000, 1'b0);
                check_case("u_pow31", 32'h8000_0000, 1'b0);
                check_case("u_max24", 32'h00ff_ffff, 1'b0);
                check_case("u_mid", 32'h0012_3456, 1'b0);
                check_case("s_pos", 32'h0000_0457, 1'b1);
                check_case("s_minus1", 32'hffff_ffff, 1'b1);
                check_case("s_min", 32'h8000_0000, 1'b1);
                check_case("s_minus5", 32'hffff_fffb, 1'b1);
                check_case("s_round_neg", 32'hfdff_fffa, 1'b1);
                check_case("u_max", 32'hffff_ffff, 1'b0);       // Rounds up to 2^32.
                check_case("u_zero", 32'h0000_0000, 1'b0);
                check_case("s_zero", 32'h0000_0000, 1'b1);
                check_case("r_tie_down", 32'h0100_0001, 1'b0);
                check_case("r_tie_up", 32'h0100_0003, 1'b0);
                check_case("r_above", 32'h0200_0003, 1'b0);
                check_case("r_below", 32'h0200_0001, 1'b0);
                check_case("r_tie_even", 32'h0200_0002, 1'b0);
                check_case("r_tie_odd", 32'h0200_0006, 1'b0);
                check_case("r_sticky_dn", 32'h1000_0009, 1'b0);
                check_case("r_sticky_up", 32'h1000_0011, 1'b0);
                check_case("r_tie_bit5", 32'h1000_0030, 1'b0);
                check_case("u_pattern", 32'h8000_0001, 1'b0);
                check_case("s_pattern", 32'h8000_0001, 1'b1);

                // Back to back requests, never more than the queue holds.
                for (int b = 0; b < N_BURSTS; b++) begin
                        for (int k = 0; k < `CONV_FIFO_DEPTH; k++) begin
                                rnd  = $urandom();
                                rsgn = 1'($urandom_range(1, 0));
                                strobe(rnd, rsgn, $sformatf("burst%0d_%0d", b, k), 1'b1);
                        end
                        in_stb = 1'b0;
                        drain();
                end

                check_flag("pre_overflow_full", 1'b0, full);
                check_flag("pre_overflow_set", 1'b0, overflow);
                overflow_burst();
                check_flag("overflow_full", 1'b1, full);
                check_flag("overflow_set", 1'b1, overflow);
                drain();
                // A dropped strobe that still got queued would show up within one conversion.
                repeat (MAX_LATENCY) @(negedge clk);
                check_flag("overflow_sticky", 1'b1, overflow);
                check_flag("full_cleared", 1'b0, full);

                print_error_counts();
                if (mismatch_count == 0 && other_count == 0) begin
                        $display("Simulation PASSED");
                end else begin
                        $display("Simulation FAILED");
                end
                $finish;
        end

endmodule

/* int_to_float.sv */
`timescale 1ns/1ps
`include "int_float_conv_config.svh"

module int_to_float (
        input  logic                   clk,
        input  logic                   rst,
        conv_req_if.conv_side          q,
        output logic                   out_stb,
        output logic [`CONV_WIDTH-1:0] out_data
);
        import fp_pkg::*;

        // Mantissa including the hidden one.
        localparam int MW = FP_MANT_BITS + 1;
        // Position of the guard bit in the shift register.
        localparam int G  = `CONV_WIDTH - MW;
        localparam logic [FP_EXP_BITS-1:0] EXP_TOP = FP_EXP_BITS'(`CONV_WIDTH - 1);
        localparam logic [FP_EXP_BITS-1:0] BIAS    = FP_EXP_BITS'(FP_EXP_BIAS);

        conv_state_t              state;
        logic                     take;
        logic                     neg;
        logic [`CONV_WIDTH-1:0]   magnitude;
        logic                     op_zero;

        logic                     sign;
        logic                     is_zero;
        logic [`CONV_WIDTH:0]     value;        // Magnitude, leading one moves to the top.
        logic [FP_EXP_BITS-1:0]   exp;          // Unbiased exponent.
        logic [MW-1:0]            mant;

        logic                     guard_bit;
        logic                     round_bit;
        logic                     sticky_bit;
        logic                     round_up;

        // Handshake with the queue.
        assign take      = (state == ST_IDLE) && q.pending;
        assign q.start   = take;
        assign q.busy    = (state != ST_IDLE);

        // Operand decode.
        assign neg       = q.req.is_signed && q.req.operand[`CONV_WIDTH-1];
        assign magnitude = neg ? -q.req.operand : q.req.operand;
        assign op_zero   = (q.req.operand == '0);

        // Bits below the mantissa once normalized.
        assign guard_bit  = value[G];
        assign round_bit  = value[G-1];
        assign sticky_bit = |value[G-2:0];
        assign round_up   = guard_bit && (round_bit || sticky_bit || value[G+1]); // Ties to even.

        assign out_stb   = (state == ST_PUT);

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state <= ST_IDLE;
                end else begin
                        case (state)
                                ST_IDLE: begin
                                        if (take) begin
                                                state <= op_zero ? ST_ROUND : ST_NORMALIZE;
                                        end
                                end
                                ST_NORMALIZE: begin
                                        if (value[`CONV_WIDTH]) begin
                                                state <= ST_ROUND;
                                        end
                                end
                                ST_ROUND: state <= ST_PACK;
                                ST_PACK:  state <= ST_PUT;
                                ST_PUT:   state <= ST_IDLE;
                                default:  state <= ST_IDLE;
                        endcase
                end
        end

        // Datapath.
        always_ff @(posedge clk) begin
                case (state)
                        ST_IDLE: begin
                                if (take) begin
                                        sign    <= neg;
                                        is_zero <= op_zero;
                                        value   <= {magnitude, 1'b0}; // Bit 32 holds operand bit 31.
                                        exp     <= EXP_TOP;
                                end
                        end
                        ST_NORMALIZE: begin
                                if (!value[`CONV_WIDTH]) begin
                                        value <= value << 1;
                                        exp   <= exp - 1'b1;
                                end
                        end
                        ST_ROUND: begin
                                if (round_up) begin
                                        mant <= value[`CONV_WIDTH -: MW] + 1'b1;
                                        // Mantissa overflow bumps the exponent.
                                        if (&value[`CONV_WIDTH -: MW]) begin
                                                exp <= exp + 1'b1;
                                        end
                                end else begin
                                        mant <= value[`CONV_WIDTH -: MW];
                                end
                        end
                        ST_PACK: begin
                                if (is_zero) begin
                                        out_data <= '0;         // Always +0.
                                end else begin
                                        out_data <= {sign, exp + BIAS, mant[FP_MANT_BITS-1:0]};
                                end
                        end
                        default: begin
                        end
                endcase
        end

endmodule
